// File: arcade_ctrl_config.svh
`ifndef ARCADE_CTRL_CONFIG_SVH
`define ARCADE_CTRL_CONFIG_SVH

// Vector widths
`define PLAYER_BITS 6
`define SYS_BITS    4
`define JOY_BITS    8

// Bit positions in player_t
`define PB_RIGHT  0
`define PB_LEFT   1
`define PB_DOWN   2
`define PB_UP     3
`define PB_FIRE_A 4
`define PB_FIRE_B 5

// Bit positions in sys_t
`define SB_COIN1  0
`define SB_COIN2  1
`define SB_START1 2
`define SB_START2 3

// Joystick word, bits 0 to 5 as in player_t
`define JB_COIN  6
`define JB_START 7

// PS/2 set 2 prefixes
`define SC_PREFIX_EXT   8'hE0
`define SC_PREFIX_BREAK 8'hF0

// Player 1, arrows need E0
`define SC_P1_RIGHT  8'h74
`define SC_P1_LEFT   8'h6B
`define SC_P1_DOWN   8'h72
`define SC_P1_UP     8'h75
`define SC_P1_FIRE_A 8'h14 // Ctrl
`define SC_P1_FIRE_B 8'h11 // Alt

// Player 2, WASD block
`define SC_P2_RIGHT  8'h23
`define SC_P2_LEFT   8'h1C
`define SC_P2_DOWN   8'h1B
`define SC_P2_UP     8'h1D
`define SC_P2_FIRE_A 8'h15
`define SC_P2_FIRE_B 8'h24

// System keys 5 6 1 2
`define SC_COIN1  8'h2E
`define SC_COIN2  8'h36
`define SC_START1 8'h16
`define SC_START2 8'h1E

`endif

// File: arcade_ctrl_pkg.sv
`include "arcade_ctrl_config.svh"

package arcade_ctrl_pkg;

	// Scancode parser, prefix tracking
	typedef enum logic [1:0] {
		KS_IDLE      = 2'd0,
		KS_EXT       = 2'd1, // after E0
		KS_BREAK     = 2'd2, // after F0
		KS_EXT_BREAK = 2'd3  // after E0 F0
	} kbd_state_e;

	// Screen rotation opcodes
	typedef enum logic [1:0] {
		ROT_NONE = 2'd0,
		ROT_CW   = 2'd1,
		ROT_CCW  = 2'd2,
		ROT_FLIP = 2'd3
	} rot_e;

	// right, left, down, up, fire A, fire B
	typedef logic [`PLAYER_BITS-1:0] player_t;

	// coin1, coin2, start1, start2
	typedef logic [`SYS_BITS-1:0] sys_t;

endpackage

// File: key_tracker.sv
`timescale 1ns/10ps
`include "arcade_ctrl_config.svh"

module key_tracker import arcade_ctrl_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n_i,
	input  logic       key_strobe_i,
	input  logic [7:0] key_byte_i,
	output player_t    kbd_p1_o,
	output player_t    kbd_p2_o,
	output sys_t       kbd_sys_o
);

	kbd_state_e state;
	logic       ext;
	logic       brk;

	// One-hot hits for the current byte
	player_t hit_p1;
	player_t hit_p2;
	sys_t    hit_sys;

	assign ext = (state == KS_EXT) || (state == KS_EXT_BREAK);
	assign brk = (state == KS_BREAK) || (state == KS_EXT_BREAK);

	// Scancode table
	always_comb begin
		hit_p1  = '0;
		hit_p2  = '0;
		hit_sys = '0;

		if (ext) begin
			case (key_byte_i)
				`SC_P1_RIGHT: hit_p1[`PB_RIGHT] = 1'b1;
				`SC_P1_LEFT:  hit_p1[`PB_LEFT]  = 1'b1;
				`SC_P1_DOWN:  hit_p1[`PB_DOWN]  = 1'b1;
				`SC_P1_UP:    hit_p1[`PB_UP]    = 1'b1;
				default: ;
			endcase
		end

		// Left or right Ctrl/Alt
		case (key_byte_i)
			`SC_P1_FIRE_A: hit_p1[`PB_FIRE_A] = 1'b1;
			`SC_P1_FIRE_B: hit_p1[`PB_FIRE_B] = 1'b1;
			default: ;
		endcase

		if (!ext) begin
			case (key_byte_i)
				`SC_P2_RIGHT:  hit_p2[`PB_RIGHT]   = 1'b1;
				`SC_P2_LEFT:   hit_p2[`PB_LEFT]    = 1'b1;
				`SC_P2_DOWN:   hit_p2[`PB_DOWN]    = 1'b1;
				`SC_P2_UP:     hit_p2[`PB_UP]      = 1'b1;
				`SC_P2_FIRE_A: hit_p2[`PB_FIRE_A]  = 1'b1;
				`SC_P2_FIRE_B: hit_p2[`PB_FIRE_B]  = 1'b1;
				`SC_COIN1:     hit_sys[`SB_COIN1]  = 1'b1;
				`SC_COIN2:     hit_sys[`SB_COIN2]  = 1'b1;
				`SC_START1:    hit_sys[`SB_START1] = 1'b1;
				`SC_START2:    hit_sys[`SB_START2] = 1'b1;
				default: ;
			endcase
		end
	end

	// Prefix FSM
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			state <= KS_IDLE;
		end else if (key_strobe_i) begin
			if (key_byte_i == `SC_PREFIX_EXT) begin
				state <= brk ? KS_EXT_BREAK : KS_EXT;
			end else if (key_byte_i == `SC_PREFIX_BREAK) begin
				state <= ext ? KS_EXT_BREAK : KS_BREAK;
			end else begin
				state <= KS_IDLE; // code complete, mapped or not
			end
		end
	end

	// Held-key bits
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			kbd_p1_o  <= '0;
			kbd_p2_o  <= '0;
			kbd_sys_o <= '0;
		end else if (key_strobe_i && key_byte_i != `SC_PREFIX_EXT &&
			key_byte_i != `SC_PREFIX_BREAK) begin
			if (brk) begin
				kbd_p1_o  <= kbd_p1_o & ~hit_p1;
				kbd_p2_o  <= kbd_p2_o & ~hit_p2;
				kbd_sys_o <= kbd_sys_o & ~hit_sys;
			end else begin
				kbd_p1_o  <= kbd_p1_o | hit_p1;
				kbd_p2_o  <= kbd_p2_o | hit_p2;
				kbd_sys_o <= kbd_sys_o | hit_sys;
			end
		end
	end

endmodule

// File: joy_rotator.sv
`timescale 1ns/10ps
`include "arcade_ctrl_config.svh"

module joy_rotator import arcade_ctrl_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic [`JOY_BITS-1:0] joy0_i,
	input  logic [`JOY_BITS-1:0] joy1_i,
	input  logic                 swap_i,
	input  logic                 rotate_i,
	input  rot_e                 orient_i,
	output player_t              joy_p1_o,
	output player_t              joy_p2_o,
	output sys_t                 joy_sys_o
);

	logic [`JOY_BITS-1:0] src_p1;
	logic [`JOY_BITS-1:0] src_p2;
	rot_e                 rot_eff;
	sys_t                 sys_d;

	// Direction remap, fire bits untouched
	function automatic player_t remap(input logic [`JOY_BITS-1:0] j, input rot_e r);
		player_t p;
		p = j[`PLAYER_BITS-1:0];
		case (r)
			ROT_CW: begin
				p[`PB_UP]    = j[`PB_RIGHT];
				p[`PB_RIGHT] = j[`PB_DOWN];
				p[`PB_DOWN]  = j[`PB_LEFT];
				p[`PB_LEFT]  = j[`PB_UP];
			end
			ROT_CCW: begin
				p[`PB_UP]    = j[`PB_LEFT];
				p[`PB_LEFT]  = j[`PB_DOWN];
				p[`PB_DOWN]  = j[`PB_RIGHT];
				p[`PB_RIGHT] = j[`PB_UP];
			end
			ROT_FLIP: begin
				p[`PB_UP]    = j[`PB_DOWN];
				p[`PB_DOWN]  = j[`PB_UP];
				p[`PB_LEFT]  = j[`PB_RIGHT];
				p[`PB_RIGHT] = j[`PB_LEFT];
			end
			default: ;
		endcase
		return p;
	endfunction

	assign src_p1  = swap_i ? joy1_i : joy0_i;
	assign src_p2  = swap_i ? joy0_i : joy1_i;
	assign rot_eff = rotate_i ? orient_i : ROT_NONE;

	always_comb begin
		sys_d             = '0;
		sys_d[`SB_COIN1]  = src_p1[`JB_COIN];
		sys_d[`SB_START1] = src_p1[`JB_START];
		sys_d[`SB_COIN2]  = src_p2[`JB_COIN];
		sys_d[`SB_START2] = src_p2[`JB_START];
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			joy_p1_o  <= '0;
			joy_p2_o  <= '0;
			joy_sys_o <= '0;
		end else begin
			joy_p1_o  <= remap(src_p1, rot_eff);
			joy_p2_o  <= remap(src_p2, rot_eff);
			joy_sys_o <= sys_d;
		end
	end

endmodule

// File: input_combiner.sv
`timescale 1ns/10ps
`include "arcade_ctrl_config.svh"

module input_combiner import arcade_ctrl_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n_i,
	input  player_t kbd_p1_i,
	input  player_t kbd_p2_i,
	input  player_t joy_p1_i,
	input  player_t joy_p2_i,
	input  sys_t    kbd_sys_i,
	input  sys_t    joy_sys_i,
	input  logic    one_player_i,
	output player_t p1_o,
	output player_t p2_o,
	output sys_t    sys_o
);

	player_t p1_clean;
	player_t p2_clean;

	// Opposing directions cancel
	function automatic player_t clean(input player_t v);
		player_t c;
		c = v;
		if (v[`PB_LEFT] && v[`PB_RIGHT]) begin
			c[`PB_LEFT]  = 1'b0;
			c[`PB_RIGHT] = 1'b0;
		end
		if (v[`PB_UP] && v[`PB_DOWN]) begin
			c[`PB_UP]   = 1'b0;
			c[`PB_DOWN] = 1'b0;
		end
		return c;
	endfunction

	assign p1_clean = clean(kbd_p1_i | joy_p1_i);
	assign p2_clean = clean(kbd_p2_i | joy_p2_i);

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			p1_o  <= '0;
			p2_o  <= '0;
			sys_o <= '0;
		end else begin
			p1_o  <= p1_clean;
			p2_o  <= one_player_i ? p1_clean : p2_clean; // alternating play
			sys_o <= kbd_sys_i | joy_sys_i;
		end
	end

endmodule

// File: arcade_ctrl_top.sv
`timescale 1ns/10ps
`include "arcade_ctrl_config.svh"

module arcade_ctrl_top import arcade_ctrl_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic                 key_strobe_i,
	input  logic [7:0]           key_byte_i,
	input  logic [`JOY_BITS-1:0] joy0_i,
	input  logic [`JOY_BITS-1:0] joy1_i,
	input  logic                 swap_i,
	input  logic                 rotate_i,
	input  rot_e                 orient_i,
	input  logic                 one_player_i,
	output player_t              p1_o,
	output player_t              p2_o,
	output sys_t                 sys_o
);

	player_t kbd_p1;
	player_t kbd_p2;
	sys_t    kbd_sys;
	player_t joy_p1;
	player_t joy_p2;
	sys_t    joy_sys;

	key_tracker u_key_tracker (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.key_strobe_i (key_strobe_i),
		.key_byte_i   (key_byte_i),
		.kbd_p1_o     (kbd_p1),
		.kbd_p2_o     (kbd_p2),
		.kbd_sys_o    (kbd_sys)
	);

	joy_rotator u_joy_rotator (
		.clk_sys   (clk_sys),
		.rst_n_i   (rst_n_i),
		.joy0_i    (joy0_i),
		.joy1_i    (joy1_i),
		.swap_i    (swap_i),
		.rotate_i  (rotate_i),
		.orient_i  (orient_i),
		.joy_p1_o  (joy_p1),
		.joy_p2_o  (joy_p2),
		.joy_sys_o (joy_sys)
	);

	// Both sources registered once, both land 2 cycles out
	input_combiner u_input_combiner (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.kbd_p1_i     (kbd_p1),
		.kbd_p2_i     (kbd_p2),
		.joy_p1_i     (joy_p1),
		.joy_p2_i     (joy_p2),
		.kbd_sys_i    (kbd_sys),
		.joy_sys_i    (joy_sys),
		.one_player_i (one_player_i),
		.p1_o         (p1_o),
		.p2_o         (p2_o),
		.sys_o        (sys_o)
	);

endmodule

// File: arcade_ctrl_tb_vectors.svh
`ifndef ARCADE_CTRL_TB_VECTORS_SVH
`define ARCADE_CTRL_TB_VECTORS_SVH

// Columns: reset, random joy, byte count, byte0..2, joy0, joy1,
// swap, rotate, orient, one_player, expected p1, p2, sys
localparam int NUM_ROWS = 57;

task automatic load_table();
	// Prefixes, make and break
	add_row(0, 0, 1, 'h75, 'h00, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 2, 'hE0, 'h75, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h08, 'h00, 'h0);
	add_row(0, 0, 2, 'hF0, 'h75, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h08, 'h00, 'h0);
	add_row(0, 0, 3, 'hE0, 'hF0, 'h75, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 2, 'h1D, 'h15, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h18, 'h0);
	add_row(0, 0, 2, 'hF0, 'h1D, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h10, 'h0);
	add_row(0, 0, 2, 'hF0, 'h15, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 2, 'hE0, 'h14, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h10, 'h00, 'h0);
	add_row(0, 0, 2, 'hF0, 'h14, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 2, 'hE0, 'h11, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h20, 'h00, 'h0);
	add_row(0, 0, 3, 'hE0, 'hF0, 'h11, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 3, 'h23, 'h1C, 'h1B, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h04, 'h0);
	add_row(0, 0, 1, 'h24, 'h00, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h24, 'h0);
	add_row(0, 0, 2, 'hF0, 'h23, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h26, 'h0);
	add_row(0, 0, 2, 'hF0, 'h1C, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h24, 'h0);
	add_row(0, 0, 2, 'hF0, 'h1B, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h20, 'h0);
	add_row(0, 0, 2, 'hF0, 'h24, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 2, 'hE0, 'h74, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h01, 'h00, 'h0);
	add_row(0, 0, 3, 'hE0, 'hF0, 'h74, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);

	// System keys, then joystick coin and start bits
	add_row(0, 0, 3, 'h2E, 'h36, 'h16, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h7);
	add_row(0, 0, 1, 'h1E, 'h00, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'hF);
	add_row(0, 0, 2, 'hF0, 'h2E, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'hE);
	add_row(0, 0, 2, 'hF0, 'h36, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'hC);
	add_row(0, 0, 2, 'hF0, 'h16, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h8);
	add_row(0, 0, 2, 'hF0, 'h1E, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h40, 'h80, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h9);
	add_row(0, 0, 1, 'h2E, 'h00, 'h00, 'h40, 'h80, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h9);
	add_row(0, 0, 2, 'hF0, 'h2E, 'h00, 'hC0, 'h40, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h7);

	// Rotation and swap
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h08, 'h01, 0, 1, ROT_CW,   0, 'h02, 'h08, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h04, 'h02, 0, 1, ROT_CW,   0, 'h01, 'h04, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h08, 'h02, 0, 1, ROT_CCW,  0, 'h01, 'h08, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h01, 'h04, 0, 1, ROT_CCW,  0, 'h04, 'h02, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h08, 'h01, 0, 1, ROT_FLIP, 0, 'h04, 'h02, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h12, 'h24, 0, 1, ROT_FLIP, 0, 'h11, 'h28, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h08, 'h02, 0, 1, ROT_NONE, 0, 'h08, 'h02, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h08, 'h02, 0, 0, ROT_CW,   0, 'h08, 'h02, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h08, 'h31, 1, 0, ROT_NONE, 0, 'h31, 'h08, 'h0);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h40, 'h80, 1, 0, ROT_NONE, 0, 'h00, 'h00, 'h6);
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h01, 'h08, 1, 1, ROT_CW,   0, 'h02, 'h08, 'h0);

	// Random joysticks, no key held here
	add_row(0, 1, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 0, 1, ROT_CW,   0, 'h00, 'h00, 'h0);
	add_row(0, 1, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 1, 1, ROT_CCW,  0, 'h00, 'h00, 'h0);
	add_row(0, 1, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 0, 1, ROT_FLIP, 1, 'h00, 'h00, 'h0);
	add_row(0, 1, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 1, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 1, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 0, 1, ROT_NONE, 0, 'h00, 'h00, 'h0);

	// Keyboard and joystick merged
	add_row(0, 0, 2, 'hE0, 'h6B, 'h00, 'h01, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 3, 'hE0, 'hF0, 'h6B, 'h01, 'h00, 0, 0, ROT_NONE, 0, 'h01, 'h00, 'h0);
	add_row(0, 0, 1, 'h14, 'h00, 'h00, 'h08, 'h00, 0, 0, ROT_NONE, 0, 'h18, 'h00, 'h0);
	add_row(0, 0, 2, 'hF0, 'h14, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 1, 'h1D, 'h00, 'h00, 'h00, 'h24, 0, 0, ROT_NONE, 0, 'h00, 'h20, 'h0);
	add_row(0, 0, 2, 'hF0, 'h1D, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);

	// One-player mirroring
	add_row(0, 0, 0, 'h00, 'h00, 'h00, 'h11, 'h2A, 0, 0, ROT_NONE, 1, 'h11, 'h11, 'h0);
	add_row(0, 0, 1, 'h15, 'h00, 'h00, 'h08, 'h04, 0, 0, ROT_NONE, 1, 'h08, 'h08, 'h0);
	add_row(0, 0, 2, 'hF0, 'h15, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);

	// Mid-run reset drops held keys and a pending E0
	add_row(0, 0, 3, 'hE0, 'h75, 'h2E, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h08, 'h00, 'h1);
	add_row(1, 0, 0, 'h00, 'h00, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(0, 0, 1, 'hE0, 'h00, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
	add_row(1, 0, 1, 'h75, 'h00, 'h00, 'h00, 'h00, 0, 0, ROT_NONE, 0, 'h00, 'h00, 'h0);
endtask

`endif

// File: arcade_ctrl_tb.sv
`timescale 1ns/10ps
`include "arcade_ctrl_config.svh"

module arcade_ctrl_tb import arcade_ctrl_pkg::*; ();

	localparam logic [31:0] RAND_SEED = 32'hdbf9de69;

	logic                 clk_sys;
	logic                 rst_n_i;
	logic                 key_strobe_i;
	logic [7:0]           key_byte_i;
	logic [`JOY_BITS-1:0] joy0_i;
	logic [`JOY_BITS-1:0] joy1_i;
	logic                 swap_i;
	logic                 rotate_i;
	rot_e                 orient_i;
	logic                 one_player_i;
	player_t              p1_o;
	player_t              p2_o;
	sys_t                 sys_o;

	`include "arcade_ctrl_tb_vectors.svh"

	localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 4 + 20;

	typedef struct packed {
		logic            do_reset;
		logic            random_joy;
		logic [1:0]      n_bytes;
		logic [0:2][7:0] key_bytes;
		logic [7:0]      joy0;
		logic [7:0]      joy1;
		logic            swap;
		logic            rotate;
		rot_e            orient;
		logic            one_player;
		player_t         exp_p1;
		player_t         exp_p2;
		sys_t            exp_sys;
	} row_t;

	row_t        rows [0:NUM_ROWS-1];
	int          row_count = 0;
	int          cur_row = -1;
	int unsigned cycle_count = 0;
	logic [31:0] rand_word;

	arcade_ctrl_top uut (
		.clk_sys      (clk_sys),
		.rst_n_i      (rst_n_i),
		.key_strobe_i (key_strobe_i),
		.key_byte_i   (key_byte_i),
		.joy0_i       (joy0_i),
		.joy1_i       (joy1_i),
		.swap_i       (swap_i),
		.rotate_i     (rotate_i),
		.orient_i     (orient_i),
		.one_player_i (one_player_i),
		.p1_o         (p1_o),
		.p2_o         (p2_o),
		.sys_o        (sys_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic add_row(input int do_reset, input int random_joy, input int n_bytes,
		input int b0, input int b1, input int b2, input int joy0, input int joy1,
		input int swap, input int rotate, input rot_e orient, input int one_player,
		input int exp_p1, input int exp_p2, input int exp_sys);
		row_t r;
		r.do_reset     = (do_reset != 0);
		r.random_joy   = (random_joy != 0);
		r.n_bytes      = n_bytes[1:0];
		r.key_bytes[0] = b0[7:0];
		r.key_bytes[1] = b1[7:0];
		r.key_bytes[2] = b2[7:0];
		r.joy0         = joy0[7:0];
		r.joy1         = joy1[7:0];
		r.swap         = (swap != 0);
		r.rotate       = (rotate != 0);
		r.orient       = orient;
		r.one_player   = (one_player != 0);
		r.exp_p1       = exp_p1[`PLAYER_BITS-1:0];
		r.exp_p2       = exp_p2[`PLAYER_BITS-1:0];
		r.exp_sys      = exp_sys[`SYS_BITS-1:0];
		if (row_count < NUM_ROWS)
			rows[row_count] = r;
		row_count++;
	endtask

	// Directions on a compass ring, up right down left
	function automatic player_t turn_directions(input logic [7:0] j, input logic rot_en,
		input rot_e orient);
		logic [3:0] ring;
		logic [3:0] turned;
		int         shift;
		int         i;
		player_t    p;
		ring  = {j[`PB_LEFT], j[`PB_DOWN], j[`PB_RIGHT], j[`PB_UP]};
		shift = 0;
		if (rot_en) begin
			case (orient)
				ROT_CW:   shift = 1;
				ROT_CCW:  shift = 3;
				ROT_FLIP: shift = 2;
				default:  shift = 0;
			endcase
		end
		for (i = 0; i < 4; i++)
			turned[i] = ring[(i + shift) % 4];
		p          = j[`PLAYER_BITS-1:0];
		p[`PB_UP]    = turned[0];
		p[`PB_RIGHT] = turned[1];
		p[`PB_DOWN]  = turned[2];
		p[`PB_LEFT]  = turned[3];
		return p;
	endfunction

	function automatic player_t cancel_opposing(input player_t v);
		player_t c;
		c = v;
		if (v[`PB_LEFT] && v[`PB_RIGHT])
			c[`PB_LEFT] = 1'b0;
		if (v[`PB_LEFT] && v[`PB_RIGHT])
			c[`PB_RIGHT] = 1'b0;
		if (v[`PB_UP] && v[`PB_DOWN]) begin
			c[`PB_UP]   = 1'b0;
			c[`PB_DOWN] = 1'b0;
		end
		return c;
	endfunction

	// Joystick only, random rows sit where no key is held
	task automatic predict_joystick(input logic [7:0] j0, input logic [7:0] j1, input row_t r,
		output player_t p1, output player_t p2, output sys_t s);
		logic [7:0] src1;
		logic [7:0] src2;
		src1 = r.swap ? j1 : j0;
		src2 = r.swap ? j0 : j1;
		p1   = cancel_opposing(turn_directions(src1, r.rotate, r.orient));
		p2   = r.one_player ? p1 : cancel_opposing(turn_directions(src2, r.rotate, r.orient));
		s    = '0;
		s[`SB_COIN1]  = src1[`JB_COIN];
		s[`SB_START1] = src1[`JB_START];
		s[`SB_COIN2]  = src2[`JB_COIN];
		s[`SB_START2] = src2[`JB_START];
	endtask

	task automatic check_player(input string name, input player_t exp_v, input player_t act_v);
		if (act_v !== exp_v) begin
			$display("[FAIL] row %0d %s expected 0x%h got 0x%h", cur_row, name, exp_v, act_v);
			$display("Simulation FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_sys(input sys_t exp_v, input sys_t act_v);
		if (act_v !== exp_v) begin
			$display("[FAIL] row %0d sys_o expected 0x%h got 0x%h", cur_row, exp_v, act_v);
			$display("Simulation FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic apply_row(input int idx);
		row_t       r;
		logic [7:0] j0;
		logic [7:0] j1;
		player_t    e1;
		player_t    e2;
		sys_t       es;
		int         k;
		r       = rows[idx];
		cur_row = idx;
		if (r.do_reset) begin
			@(negedge clk_sys);
			key_strobe_i = 1'b0;
			rst_n_i      = 1'b0;
			repeat (4) @(negedge clk_sys);
			rst_n_i = 1'b1;
		end
		for (k = 0; k < r.n_bytes; k++) begin
			@(negedge clk_sys);
			key_strobe_i = 1'b1;
			key_byte_i   = r.key_bytes[k];
		end
		@(negedge clk_sys);
		key_strobe_i = 1'b0;
		key_byte_i   = 8'h00;
		if (r.random_joy) begin
			rand_word = $urandom;
			j0        = rand_word[7:0];
			j1        = rand_word[15:8];
			predict_joystick(j0, j1, r, e1, e2, es);
		end else begin
			j0 = r.joy0;
			j1 = r.joy1;
			e1 = r.exp_p1;
			e2 = r.exp_p2;
			es = r.exp_sys;
		end
		joy0_i       = j0;
		joy1_i       = j1;
		swap_i       = r.swap;
		rotate_i     = r.rotate;
		orient_i     = r.orient;
		one_player_i = r.one_player;
		repeat (3) @(negedge clk_sys);
		check_player("p1_o", e1, p1_o);
		check_player("p2_o", e2, p2_o);
		check_sys(es, sys_o);
	endtask

	initial begin
		rst_n_i      = 1'b0;
		key_strobe_i = 1'b0;
		key_byte_i   = 8'h00;
		joy0_i       = 8'h00;
		joy1_i       = 8'h00;
		swap_i       = 1'b0;
		rotate_i     = 1'b0;
		orient_i     = ROT_NONE;
		one_player_i = 1'b0;
		rand_word    = $urandom(RAND_SEED);
		load_table();
		if (row_count != NUM_ROWS) begin
			$display("Vector table holds %0d rows but declares %0d", row_count, NUM_ROWS);
			$display("Simulation FAILED");
			$fatal(1, "bad vector table");
		end
		repeat (4) @(negedge clk_sys);
		rst_n_i = 1'b1;
		check_player("p1_o", 6'h00, p1_o); // state right out of reset
		check_player("p2_o", 6'h00, p2_o);
		check_sys(4'h0, sys_o);
		for (int idx = 0; idx < NUM_ROWS; idx++)
			apply_row(idx);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: arcade_ctrl.f
+incdir+.
arcade_ctrl_pkg.sv
key_tracker.sv
joy_rotator.sv
input_combiner.sv
arcade_ctrl_top.sv
arcade_ctrl_tb.sv
